// ==== compile.f ====
+incdir+hdl
hdl/bpu_pkg.sv
hdl/ftq_pkg.sv
hdl/bpu_train_if.sv
hdl/ftb.sv
hdl/bimodal_predictor.sv
hdl/bpu.sv
verif/tb_bpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_bpu
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_bpu.sv ====
////////////////////////////////////////
// Testbench for the branch prediction unit
// LFSR stimulus, FTB and counter model,
// assertions, watchdog
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "bpu_cfg.svh"

module tb_bpu;

    localparam int NUM_STEPS = 200;
    localparam int WATCHDOG_NS = (NUM_STEPS * 20 + 4) * 100;
    localparam logic [31:0] IDLE_PC = 32'h0000_0100;

    logic clk = 1'b0;
    logic rst_n_i, backend_flush_i, ftq_full_i;
    logic [31:0] pc_i;
    logic p0_valid_o, p0_cross_cacheline_o, p0_taken_o;
    logic [31:0] p0_start_pc_o;
    logic [2:0] p0_length_o;
    logic p1_valid_o, p1_cross_cacheline_o, p1_taken_o;
    logic [31:0] p1_start_pc_o;
    logic [2:0] p1_length_o;
    logic meta_valid_o, meta_ftb_hit_o;
    logic [1:0] meta_ctr_o;
    logic train_valid_i, train_conditional_i, train_taken_i, train_pred_taken_i;
    logic train_ftb_hit_i, train_ftb_dirty_i, train_cross_cacheline_i;
    logic [31:0] train_pc_i, train_target_i, train_fall_through_i;
    logic [1:0] train_ctr_i;
    logic main_redirect_o;
    logic [31:0] main_redirect_pc_o;

    bpu i_dut (.*);

    always #50 clk = ~clk;

    ////////////////////////////////////////
    // Reference model state
    ////////////////////////////////////////
    logic        m_valid [64];
    logic [23:0] m_tag [64];
    logic [31:0] m_tgt [64];
    logic [31:0] m_ft [64];
    logic        m_cc [64];
    logic [1:0]  m_ctr [256];
    // Expected P1 view of the last query
    logic        e_hit, e_cc, delay_m;
    logic [31:0] e_pc, e_tgt, e_ft;
    logic [1:0]  e_ctr, last_meta_ctr;
    // Training waiting for the next drive edge
    logic        t_valid, t_cond, t_taken, t_pred, t_hit, t_dirty, t_cc;
    logic [31:0] t_pc, t_tgt, t_ft;
    logic [1:0]  t_ctr;
    logic [15:0] lfsr_q = 16'd42257;

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return r;
    endfunction

    function automatic logic model_hit(input logic [31:0] pc);
        return m_valid[pc[7:2]] && (m_tag[pc[7:2]] == pc[31:8]);
    endfunction

    task automatic fail_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        $display("FAILED at %0t ns: %s expected %h actual %h", $time, name, exp, act);
        $display("** FAIL **");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic fail_text(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        assert (exp == act) else fail_value(name, exp, act);
    endtask

    // A P1 block only exists with a redirect
    assert property (@(posedge clk) disable iff (!rst_n_i) !(p1_valid_o && !main_redirect_o))
        else fail_text("P1 block valid without a redirect");

    task automatic set_train(input logic [31:0] pc, input logic cond, input logic taken,
                             input logic pred, input logic dirty, input logic [31:0] tgt,
                             input logic [31:0] ft);
        t_valid = 1'b1;
        t_pc = pc;
        t_cond = cond;
        t_taken = taken;
        t_pred = pred;
        t_hit = model_hit(pc);
        t_dirty = dirty;
        t_cc = pc[2];
        t_tgt = tgt;
        t_ft = ft;
        t_ctr = m_ctr[pc[9:2]];
    endtask

    ////////////////////////////////////////
    // One cycle of drive, check and model update
    ////////////////////////////////////////
    task automatic step(input logic [31:0] pc, input logic full, input logic flush);
        logic exp_redir, mis, cut;
        logic [11:0] off;
        logic [2:0] exp_len;
        @(negedge clk);
        pc_i = pc;
        ftq_full_i = full;
        backend_flush_i = flush;
        train_valid_i = t_valid;
        train_pc_i = t_pc;
        train_conditional_i = t_cond;
        train_taken_i = t_taken;
        train_pred_taken_i = t_pred;
        train_ftb_hit_i = t_hit;
        train_ftb_dirty_i = t_dirty;
        train_cross_cacheline_i = t_cc;
        train_target_i = t_tgt;
        train_fall_through_i = t_ft;
        train_ctr_i = t_ctr;
        #1;
        // P0 next-line block
        off = pc[11:0];
        cut = off > 12'hFF0;
        exp_len = cut ? 3'((13'h1000 - {1'b0, off}) >> 2) : 3'd4;
        check_val("p0_valid_o", {31'd0, ~full}, {31'd0, p0_valid_o});
        check_val("p0_start_pc_o", full ? 32'd0 : pc, p0_start_pc_o);
        check_val("p0_length_o", full ? 32'd0 : {29'd0, exp_len}, {29'd0, p0_length_o});
        check_val("p0_cross_cacheline_o", {31'd0, ~full & (pc[3:2] != 2'd0) & ~cut},
                  {31'd0, p0_cross_cacheline_o});
        check_val("p0_taken_o", 32'd0, {31'd0, p0_taken_o});
        // P1 result of the previous query
        exp_redir = e_hit & ~delay_m;
        check_val("main_redirect_o", {31'd0, exp_redir}, {31'd0, main_redirect_o});
        check_val("meta_valid_o", {31'd0, e_hit}, {31'd0, meta_valid_o});
        check_val("meta_ftb_hit_o", {31'd0, e_hit}, {31'd0, meta_ftb_hit_o});
        check_val("meta_ctr_o", {30'd0, e_ctr}, {30'd0, meta_ctr_o});
        if (exp_redir) begin
            check_val("main_redirect_pc_o", e_ctr[1] ? e_tgt : e_ft, main_redirect_pc_o);
        end
        check_val("p1_valid_o", {31'd0, exp_redir & ~full}, {31'd0, p1_valid_o});
        if (exp_redir && !full) begin
            check_val("p1_start_pc_o", e_pc, p1_start_pc_o);
            check_val("p1_length_o", {29'd0, 3'(e_ft[4:2] - e_pc[4:2])}, {29'd0, p1_length_o});
            check_val("p1_cross_cacheline_o", {31'd0, e_cc}, {31'd0, p1_cross_cacheline_o});
            check_val("p1_taken_o", {31'd0, e_ctr[1]}, {31'd0, p1_taken_o});
        end
        last_meta_ctr = meta_ctr_o;
        // Arrays read before this edge's training lands
        delay_m = flush | (exp_redir & ~full);
        e_pc = pc;
        e_hit = model_hit(pc);
        e_ctr = m_ctr[pc[9:2]];
        e_tgt = m_tgt[pc[7:2]];
        e_ft = m_ft[pc[7:2]];
        e_cc = m_cc[pc[7:2]];
        if (t_valid) begin
            mis = t_pred ^ t_taken;
            if (t_cond && ((mis && !t_hit) || (t_dirty && t_hit))) begin
                m_valid[t_pc[7:2]] = !(t_dirty && t_hit);
                m_tag[t_pc[7:2]] = t_pc[31:8];
                m_tgt[t_pc[7:2]] = t_tgt;
                m_ft[t_pc[7:2]] = t_ft;
                m_cc[t_pc[7:2]] = t_cc;
            end
            if (t_hit || mis) begin
                if (t_taken) begin
                    m_ctr[t_pc[9:2]] = (t_ctr == 2'd3) ? 2'd3 : t_ctr + 2'd1;
                end else begin
                    m_ctr[t_pc[9:2]] = (t_ctr == 2'd0) ? 2'd0 : t_ctr - 2'd1;
                end
            end
        end
        t_valid = 1'b0;
    endtask

    // Query and then look at its P1 result
    task automatic query(input logic [31:0] pc);
        step(pc, 1'b0, 1'b0);
        step(IDLE_PC, 1'b0, 1'b0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_text("watchdog expired before the tests completed");
    end

    initial begin
        logic [31:0] pc, a, b, r;
        for (int i = 0; i < 64; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i] = '0;
            m_tgt[i] = '0;
            m_ft[i] = '0;
            m_cc[i] = 1'b0;
        end
        for (int i = 0; i < 256; i++) begin
            m_ctr[i] = 2'b01;
        end
        {e_hit, e_cc, e_pc, e_tgt, e_ft} = '0;
        e_ctr = 2'b01;
        delay_m = 1'b1;
        {t_valid, t_cond, t_taken, t_pred, t_hit, t_dirty, t_cc} = '0;
        {t_pc, t_tgt, t_ft, t_ctr} = '0;
        rst_n_i = 1'b0;
        {backend_flush_i, ftq_full_i, pc_i} = '0;
        {train_valid_i, train_conditional_i, train_taken_i, train_pred_taken_i} = '0;
        {train_ftb_hit_i, train_ftb_dirty_i, train_cross_cacheline_i} = '0;
        {train_pc_i, train_target_i, train_fall_through_i, train_ctr_i} = '0;
        repeat (4) @(negedge clk);
        rst_n_i = 1'b1;

        // P0 blocks on a cold FTB with some near a page end
        for (int i = 0; i < 40; i++) begin
            pc = rand_bits(30) << 2;
            if (i % 4 == 0) begin
                pc[11:4] = 8'hFF;
            end
            step(pc, 1'b0, 1'b0);
        end

        // Install a taken branch so the counter moves from 01 to 10
        a = 32'h0000_1240;
        set_train(a, 1'b1, 1'b1, 1'b0, 1'b0, 32'h2000_0000, a + 32'd12);
        step(IDLE_PC, 1'b0, 1'b0);
        query(a);

        // Two not-taken trainings with the returned counter
        for (int k = 0; k < 2; k++) begin
            set_train(a, 1'b1, 1'b0, 1'b1, 1'b0, 32'h2000_0000, a + 32'd12);
            t_ctr = last_meta_ctr;
            step(IDLE_PC, 1'b0, 1'b0);
            query(a);
        end

        // Dirty hit invalidates the entry
        set_train(a, 1'b1, 1'b0, 1'b0, 1'b1, 32'h2000_0000, a + 32'd12);
        step(IDLE_PC, 1'b0, 1'b0);
        query(a);

        // Random branches against the counter model
        for (int i = 0; i < 30; i++) begin
            pc = rand_bits(30) << 2;
            r = rand_bits(2);
            set_train(pc, 1'b1, r[0], r[1], 1'b0, rand_bits(30) << 2,
                      pc + (rand_bits(2) << 2) + 32'd4);
            step(IDLE_PC, 1'b0, 1'b0);
            query(pc);
        end

        // Back-pressure keeps the redirect and drops both blocks
        b = 32'h0000_3004;
        set_train(b, 1'b1, 1'b1, 1'b0, 1'b0, 32'h0040_0000, b + 32'd8);
        step(IDLE_PC, 1'b0, 1'b0);
        step(b, 1'b0, 1'b0);
        step(b, 1'b1, 1'b0);
        query(b);

        // Flush hides one redirect and the next query redirects again
        step(b, 1'b0, 1'b1);
        step(IDLE_PC, 1'b0, 1'b0);
        query(b);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/bpu.sv ====
////////////////////////////////////////
// Branch prediction unit, top level
// P0 next-line block, P1 FTB override,
// redirect and FTQ training policy
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "bpu_cfg.svh"

module bpu (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        backend_flush_i,
    // Query
    input  logic [`BPU_ADDR_WIDTH-1:0]  pc_i,
    input  logic                        ftq_full_i,
    // P0 fetch block
    output logic                        p0_valid_o,
    output logic [`BPU_ADDR_WIDTH-1:0]  p0_start_pc_o,
    output logic [`BPU_LEN_WIDTH-1:0]   p0_length_o,
    output logic                        p0_cross_cacheline_o,
    output logic                        p0_taken_o,
    // P1 fetch block
    output logic                        p1_valid_o,
    output logic [`BPU_ADDR_WIDTH-1:0]  p1_start_pc_o,
    output logic [`BPU_LEN_WIDTH-1:0]   p1_length_o,
    output logic                        p1_cross_cacheline_o,
    output logic                        p1_taken_o,
    // Prediction metadata
    output logic                        meta_valid_o,
    output logic                        meta_ftb_hit_o,
    output logic [`BPU_CTR_WIDTH-1:0]   meta_ctr_o,
    // Training from the FTQ
    input  logic                        train_valid_i,
    input  logic [`BPU_ADDR_WIDTH-1:0]  train_pc_i,
    input  logic                        train_conditional_i,
    input  logic                        train_taken_i,
    input  logic                        train_pred_taken_i,
    input  logic                        train_ftb_hit_i,
    input  logic                        train_ftb_dirty_i,
    input  logic                        train_cross_cacheline_i,
    input  logic [`BPU_ADDR_WIDTH-1:0]  train_target_i,
    input  logic [`BPU_ADDR_WIDTH-1:0]  train_fall_through_i,
    input  logic [`BPU_CTR_WIDTH-1:0]   train_ctr_i,
    // PC redirect
    output logic                        main_redirect_o,
    output logic [`BPU_ADDR_WIDTH-1:0]  main_redirect_pc_o
);
    import bpu_pkg::*;
    import ftq_pkg::*;

    localparam int OFS = `BPU_WORD_OFFSET;
    localparam int LEN_W = `BPU_LEN_WIDTH;
    localparam int PG = `BPU_PAGE_BITS;
    // Last page offset where a full block still fits
    localparam logic [PG-1:0] PAGE_LIMIT = PG'((1 << PG) - 4 * `BPU_FETCH_WIDTH);

    bpu_train_if train_bus ();

    ftb_entry_t ftb_entry;
    logic ftb_hit;
    logic [`BPU_CTR_WIDTH-1:0] ctr;
    logic [`BPU_ADDR_WIDTH-1:0] p1_pc_q;
    logic flush_delay_q;
    logic main_redirect;

    ////////////////////////////////////////
    // P0 next-line block
    ////////////////////////////////////////
    fetch_block_t p0_blk;
    logic cross_page;
    logic [PG-1:0] page_rem;

    assign cross_page = pc_i[PG-1:0] > PAGE_LIMIT;
    // Bytes left before the page end
    assign page_rem = PG'(0) - pc_i[PG-1:0];

    always_comb begin
        p0_blk = '0;
        if (!ftq_full_i) begin
            p0_blk.valid = 1'b1;
            p0_blk.start_pc = pc_i;
            p0_blk.length = cross_page ? page_rem[OFS +: LEN_W] : LEN_W'(`BPU_FETCH_WIDTH);
            // A block cut at the page end stays in its line
            p0_blk.is_cross_cacheline =
                (pc_i[OFS +: $clog2(`BPU_FETCH_WIDTH)] != '0) & ~cross_page;
            p0_blk.predicted_taken = 1'b0;
        end
    end

    assign p0_valid_o = p0_blk.valid;
    assign p0_start_pc_o = p0_blk.start_pc;
    assign p0_length_o = p0_blk.length;
    assign p0_cross_cacheline_o = p0_blk.is_cross_cacheline;
    assign p0_taken_o = p0_blk.predicted_taken;

    ////////////////////////////////////////
    // P1 FTB override and redirect
    ////////////////////////////////////////
    fetch_block_t p1_blk;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            p1_pc_q <= '0;
            flush_delay_q <= 1'b1;
        end else begin
            p1_pc_q <= pc_i;
            // Skip one redirect after a flush or a taken redirect
            flush_delay_q <= backend_flush_i | (main_redirect & ~ftq_full_i);
        end
    end

    assign main_redirect = ftb_hit & ~flush_delay_q;

    always_comb begin
        p1_blk = '0;
        if (main_redirect && !ftq_full_i) begin
            p1_blk.valid = 1'b1;
            p1_blk.start_pc = p1_pc_q;
            // Low word bits only, wraps cleanly in LEN_W bits
            p1_blk.length = ftb_entry.fall_through_address[OFS +: LEN_W] - p1_pc_q[OFS +: LEN_W];
            p1_blk.is_cross_cacheline = ftb_entry.is_cross_cacheline;
            p1_blk.predicted_taken = ctr[`BPU_CTR_WIDTH-1];
        end
    end

    assign p1_valid_o = p1_blk.valid;
    assign p1_start_pc_o = p1_blk.start_pc;
    assign p1_length_o = p1_blk.length;
    assign p1_cross_cacheline_o = p1_blk.is_cross_cacheline;
    assign p1_taken_o = p1_blk.predicted_taken;

    // Redirect is reported even under back-pressure
    assign main_redirect_o = main_redirect;
    assign main_redirect_pc_o = ctr[`BPU_CTR_WIDTH-1] ? ftb_entry.jump_target_address
                                                      : ftb_entry.fall_through_address;

    // Metadata for the FTQ to hand back at training
    pred_meta_t meta;
    assign meta.valid = ftb_hit;
    assign meta.ftb_hit = ftb_hit;
    assign meta.ctr = ctr;

    assign meta_valid_o = meta.valid;
    assign meta_ftb_hit_o = meta.ftb_hit;
    assign meta_ctr_o = meta.ctr;

    ////////////////////////////////////////
    // Update policy
    ////////////////////////////////////////
    ftq_train_t trn;
    logic mispredict;
    logic dirty_hit;

    always_comb begin
        trn.valid = train_valid_i;
        trn.start_pc = train_pc_i;
        trn.is_conditional = train_conditional_i;
        trn.is_taken = train_taken_i;
        trn.predicted_taken = train_pred_taken_i;
        trn.ftb_hit = train_ftb_hit_i;
        trn.ftb_dirty = train_ftb_dirty_i;
        trn.is_cross_cacheline = train_cross_cacheline_i;
        trn.jump_target_address = train_target_i;
        trn.fall_through_address = train_fall_through_i;
        trn.meta.valid = train_ftb_hit_i;
        trn.meta.ftb_hit = train_ftb_hit_i;
        trn.meta.ctr = train_ctr_i;
    end

    assign mispredict = trn.predicted_taken ^ trn.is_taken;
    assign dirty_hit = trn.ftb_dirty & trn.ftb_hit;

    // Install on first mispredicted miss, invalidate on a dirty hit
    assign train_bus.ftb_we = trn.valid & trn.is_conditional & ((mispredict & ~trn.ftb_hit) | dirty_hit);

    always_comb begin
        train_bus.ftb_entry.valid = ~dirty_hit;
        train_bus.ftb_entry.tag = trn.start_pc[`BPU_ADDR_WIDTH-1 -: `BPU_FTB_TAG_WIDTH];
        train_bus.ftb_entry.is_cross_cacheline = trn.is_cross_cacheline;
        train_bus.ftb_entry.jump_target_address = trn.jump_target_address;
        train_bus.ftb_entry.fall_through_address = trn.fall_through_address;
    end

    assign train_bus.pc = trn.start_pc;
    // Counters move on known branches and on any mispredict
    assign train_bus.pht_we = trn.valid & (trn.ftb_hit | mispredict);
    assign train_bus.taken = trn.is_taken;
    assign train_bus.ctr = trn.meta.ctr;

    ////////////////////////////////////////
    // Arrays
    ////////////////////////////////////////
    ftb i_ftb (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .query_pc_i (pc_i),
        .entry_o    (ftb_entry),
        .hit_o      (ftb_hit),
        .train      (train_bus.ftb_side)
    );

    bimodal_predictor i_bimodal_predictor (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .query_pc_i (pc_i),
        .ctr_o      (ctr),
        .train      (train_bus.pht_side)
    );

endmodule

`default_nettype wire

// ==== hdl/bimodal_predictor.sv ====
////////////////////////////////////////
// Bimodal direction predictor
// PC-indexed saturating counters
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "bpu_cfg.svh"

module bimodal_predictor (
    input  logic                       clk,
    input  logic                       rst_n_i,
    // Query side
    input  logic [`BPU_ADDR_WIDTH-1:0] query_pc_i,
    output logic [`BPU_CTR_WIDTH-1:0]  ctr_o,
    // Training side
    bpu_train_if.pht_side              train
);

    localparam int IDX_W = `BPU_PHT_IDX_WIDTH;
    localparam int CTR_W = `BPU_CTR_WIDTH;
    localparam int OFS = `BPU_WORD_OFFSET;

    // Weakly not-taken, 01 for 2-bit counters
    localparam logic [CTR_W-1:0] CTR_INIT = {1'b0, {(CTR_W - 1){1'b1}}};
    localparam logic [CTR_W-1:0] CTR_MAX = '1;
    localparam logic [CTR_W-1:0] CTR_MIN = '0;

    logic [CTR_W-1:0] ctr_q [`BPU_PHT_DEPTH];

    logic [IDX_W-1:0] query_idx;
    logic [IDX_W-1:0] wr_idx;
    logic [CTR_W-1:0] ctr_next;

    assign query_idx = query_pc_i[OFS +: IDX_W];
    assign wr_idx = train.pc[OFS +: IDX_W];

    ////////////////////////////////////////
    // Saturating step
    ////////////////////////////////////////
    // Starts from the value the query saw, not the array
    always_comb begin
        if (train.taken) begin
            ctr_next = (train.ctr == CTR_MAX) ? CTR_MAX : train.ctr + 1'b1;
        end else begin
            ctr_next = (train.ctr == CTR_MIN) ? CTR_MIN : train.ctr - 1'b1;
        end
    end

    ////////////////////////////////////////
    // Counter table
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BPU_PHT_DEPTH; i++) begin
                ctr_q[i] <= CTR_INIT;
            end
        end else if (train.pht_we) begin
            ctr_q[wr_idx] <= ctr_next;
        end
    end

    // Registered read, result belongs to P1
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ctr_o <= CTR_INIT;
        end else begin
            ctr_o <= ctr_q[query_idx];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ftb.sv ====
////////////////////////////////////////
// Fetch target buffer
// Direct mapped, registered read,
// single-cycle write from the training bus
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "bpu_cfg.svh"

module ftb (
    input  logic                       clk,
    input  logic                       rst_n_i,
    // Query side
    input  logic [`BPU_ADDR_WIDTH-1:0] query_pc_i,
    output bpu_pkg::ftb_entry_t        entry_o,
    output logic                       hit_o,
    // Update side
    bpu_train_if.ftb_side              train
);
    import bpu_pkg::*;

    localparam int IDX_W = `BPU_FTB_IDX_WIDTH;
    localparam int TAG_W = `BPU_FTB_TAG_WIDTH;
    localparam int OFS = `BPU_WORD_OFFSET;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////
    // Valid bits kept apart so reset only touches them
    logic [`BPU_FTB_DEPTH-1:0] valid_q;
    ftb_entry_t data_q [`BPU_FTB_DEPTH];

    logic [IDX_W-1:0] query_idx;
    logic [IDX_W-1:0] wr_idx;

    // Index sits just above the word offset
    assign query_idx = query_pc_i[OFS +: IDX_W];
    assign wr_idx = train.pc[OFS +: IDX_W];

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////
    logic rd_valid_q;
    ftb_entry_t rd_data_q;
    logic [TAG_W-1:0] rd_tag_q;

    // Valid read is cleared by reset so P1 starts cold
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= valid_q[query_idx];
        end
    end

    // Payload and query tag follow the PC into P1
    always_ff @(posedge clk) begin
        rd_data_q <= data_q[query_idx];
        rd_tag_q <= query_pc_i[`BPU_ADDR_WIDTH-1 -: TAG_W];
    end

    // Stored valid bit replaces the payload copy
    always_comb begin
        entry_o = rd_data_q;
        entry_o.valid = rd_valid_q;
    end

    // Hit needs a live entry with a matching tag
    assign hit_o = rd_valid_q & (rd_data_q.tag == rd_tag_q);

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////
    // Dirty invalidation arrives as a write with valid low
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (train.ftb_we) begin
            valid_q[wr_idx] <= train.ftb_entry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (train.ftb_we) begin
            data_q[wr_idx] <= train.ftb_entry;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bpu_train_if.sv ====
////////////////////////////////////////
// Training bus from the BPU core logic
// to the FTB and the direction table
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "bpu_cfg.svh"

interface bpu_train_if;
    import bpu_pkg::*;

    // FTB write strobe and new entry
    logic ftb_we;
    ftb_entry_t ftb_entry;
    // Branch PC, indexes both arrays
    logic [`BPU_ADDR_WIDTH-1:0] pc;
    // Counter write strobe and direction
    logic pht_we;
    logic taken;
    // Counter value returned in the metadata
    logic [`BPU_CTR_WIDTH-1:0] ctr;

    modport core (output ftb_we, ftb_entry, pc, pht_we, taken, ctr);
    modport ftb_side (input ftb_we, ftb_entry, pc);
    modport pht_side (input pht_we, pc, taken, ctr);

endinterface

`default_nettype wire

// ==== hdl/ftq_pkg.sv ====
////////////////////////////////////////
// Training-side types
// Prediction metadata and resolved branch
////////////////////////////////////////

`default_nettype none

`include "bpu_cfg.svh"

package ftq_pkg;

    // Metadata saved by the FTQ at prediction time
    typedef struct packed {
        logic valid;
        logic ftb_hit;
        // Counter value seen by the query
        logic [`BPU_CTR_WIDTH-1:0] ctr;
    } pred_meta_t;

    ////////////////////////////////////////
    // Resolved branch record from the FTQ
    ////////////////////////////////////////
    typedef struct packed {
        logic valid;
        logic [`BPU_ADDR_WIDTH-1:0] start_pc;
        logic is_conditional;
        // Actual outcome from the backend
        logic is_taken;
        // Outcome the BPU guessed
        logic predicted_taken;
        logic ftb_hit;
        // FTB entry found stale by the backend
        logic ftb_dirty;
        logic is_cross_cacheline;
        logic [`BPU_ADDR_WIDTH-1:0] jump_target_address;
        logic [`BPU_ADDR_WIDTH-1:0] fall_through_address;
        // Metadata returned untouched
        pred_meta_t meta;
    } ftq_train_t;

endpackage

`default_nettype wire

// ==== hdl/bpu_pkg.sv ====
////////////////////////////////////////
// Prediction-side types
// FTB entry and fetch block for the FTQ
////////////////////////////////////////

`default_nettype none

`include "bpu_cfg.svh"

package bpu_pkg;

    ////////////////////////////////////////
    // Fetch target buffer entry
    ////////////////////////////////////////
    typedef struct packed {
        // Entry holds a live branch
        logic valid;
        // PC bits above index and word offset
        logic [`BPU_FTB_TAG_WIDTH-1:0] tag;
        // Block spans two cachelines
        logic is_cross_cacheline;
        // Taken path
        logic [`BPU_ADDR_WIDTH-1:0] jump_target_address;
        // Not-taken path, end of the block
        logic [`BPU_ADDR_WIDTH-1:0] fall_through_address;
    } ftb_entry_t;

    ////////////////////////////////////////
    // Fetch block sent to the FTQ
    ////////////////////////////////////////
    typedef struct packed {
        // Qualifies the whole block
        logic valid;
        // First instruction address
        logic [`BPU_ADDR_WIDTH-1:0] start_pc;
        // Instructions in the block, 0 to fetch width
        logic [`BPU_LEN_WIDTH-1:0] length;
        logic is_cross_cacheline;
        // Direction guess for the ending branch
        logic predicted_taken;
    } fetch_block_t;

endpackage

`default_nettype wire

// ==== hdl/bpu_cfg.svh ====
////////////////////////////////////////
// Branch predictor configuration macros
// Sizes of the FTB, the counter table and
// the fetch block, plus derived widths
////////////////////////////////////////

`ifndef BPU_CFG_SVH
`define BPU_CFG_SVH

// Fetch address width in bits
`define BPU_ADDR_WIDTH 32
// Fetch target buffer entries
`define BPU_FTB_DEPTH 64
// Direction counters in the bimodal table
`define BPU_PHT_DEPTH 256
// Saturating counter width
`define BPU_CTR_WIDTH 2
// Instructions per fetch block
`define BPU_FETCH_WIDTH 4

// Derived widths
`define BPU_WORD_OFFSET 2
`define BPU_FTB_IDX_WIDTH $clog2(`BPU_FTB_DEPTH)
`define BPU_FTB_TAG_WIDTH (`BPU_ADDR_WIDTH - `BPU_FTB_IDX_WIDTH - `BPU_WORD_OFFSET)
`define BPU_PHT_IDX_WIDTH $clog2(`BPU_PHT_DEPTH)
// Block length counts 0..FETCH_WIDTH
`define BPU_LEN_WIDTH ($clog2(`BPU_FETCH_WIDTH) + 1)
// 4 KB page offset bits
`define BPU_PAGE_BITS 12

`endif
